// ==== rtl/axi_proto_pkg.sv ====
// AXI protocol field types
`default_nettype none

package axi_proto_pkg;

  // Burst length minus one
  typedef logic [7:0] len_t;
  // Log2 of the bytes in one beat
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;
  typedef logic [3:0] cache_t;

  // Wide enough for any address bus in use
  typedef logic [63:0] largest_addr_t;

  // Burst kinds
  localparam burst_t BurstFixed = 2'b00;
  localparam burst_t BurstIncr  = 2'b01;

  // Response codes
  localparam resp_t RespOkay = 2'b00;

  // AxCACHE bit that allows reshaping the burst
  localparam cache_t CacheModifiable = 4'b0010;

  // Clears the address bits below the given beat size
  function automatic largest_addr_t aligned_addr(input largest_addr_t addr,
                                                 input size_t         size);
    largest_addr_t mask;
    mask = (largest_addr_t'(1) << size) - largest_addr_t'(1);
    return addr & ~mask;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/dw_chan_pkg.sv ====
// Narrow and wide AXI channel structs
`default_nettype none

package dw_chan_pkg;

  import axi_proto_pkg::*;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned IdWidth      = 4;
  localparam int unsigned SlvDataWidth = 32;
  localparam int unsigned MstDataWidth = 64;
  localparam int unsigned SlvStrbWidth = SlvDataWidth / 8;
  localparam int unsigned MstStrbWidth = MstDataWidth / 8;
  // Byte count of a wide beat as a size code
  localparam int unsigned MstSizeLog   = 3;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [IdWidth-1:0]   id_t;

  // Requests keep the same layout on both sides
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } aw_chan_t;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } ar_chan_t;

  typedef struct packed {
    logic [SlvDataWidth-1:0] data;
    logic [SlvStrbWidth-1:0] strb;
    logic                    last;
  } slv_w_chan_t;

  typedef struct packed {
    logic [MstDataWidth-1:0] data;
    logic [MstStrbWidth-1:0] strb;
    logic                    last;
  } mst_w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t                     id;
    logic [SlvDataWidth-1:0] data;
    resp_t                   resp;
    logic                    last;
  } slv_r_chan_t;

  typedef struct packed {
    id_t                     id;
    logic [MstDataWidth-1:0] data;
    resp_t                   resp;
    logic                    last;
  } mst_r_chan_t;

endpackage

`default_nettype wire

// ==== rtl/upsize_burst_plan.sv ====
// Wide burst planner
`default_nettype none

module upsize_burst_plan #(
  parameter type ax_chan_t = dw_chan_pkg::aw_chan_t
) (
  input  ax_chan_t ax_i,
  output ax_chan_t ax_o,
  output logic     upsize_o
);

  import axi_proto_pkg::*;
  import dw_chan_pkg::*;

  logic  modifiable_incr;
  addr_t first_beat;
  addr_t last_beat;
  addr_t wide_start;
  addr_t wide_end;

  // Only modifiable INCR bursts may be reshaped
  assign modifiable_incr = (|(ax_i.cache & CacheModifiable)) && (ax_i.burst == BurstIncr);

  // First beat rounded down to the narrow size, then the start of the last narrow beat
  assign first_beat = addr_t'(aligned_addr(largest_addr_t'(ax_i.addr), ax_i.size));
  assign last_beat  = first_beat + (addr_t'(ax_i.len) << ax_i.size);

  // Wide words holding the first and the last narrow beat
  assign wide_start = addr_t'(aligned_addr(largest_addr_t'(ax_i.addr), size_t'(MstSizeLog)));
  assign wide_end   = addr_t'(aligned_addr(largest_addr_t'(last_beat), size_t'(MstSizeLog)));

  always_comb begin
    ax_o     = ax_i;
    upsize_o = modifiable_incr;
    if (modifiable_incr) begin
      // Number of wide words spanned, minus one
      ax_o.len  = len_t'((wide_end - wide_start) >> MstSizeLog);
      ax_o.size = size_t'(MstSizeLog);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/upsize_write_ctrl.sv ====
// Upsizer write path
`default_nettype none

module upsize_write_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dw_chan_pkg::aw_chan_t    slv_aw_i,
  input  logic                     slv_aw_valid_i,
  output logic                     slv_aw_ready_o,
  input  dw_chan_pkg::slv_w_chan_t slv_w_i,
  input  logic                     slv_w_valid_i,
  output logic                     slv_w_ready_o,
  output dw_chan_pkg::b_chan_t     slv_b_o,
  output logic                     slv_b_valid_o,
  input  logic                     slv_b_ready_i,
  output dw_chan_pkg::aw_chan_t    mst_aw_o,
  output logic                     mst_aw_valid_o,
  input  logic                     mst_aw_ready_i,
  output dw_chan_pkg::mst_w_chan_t mst_w_o,
  output logic                     mst_w_valid_o,
  input  logic                     mst_w_ready_i,
  input  dw_chan_pkg::b_chan_t     mst_b_i,
  input  logic                     mst_b_valid_i,
  output logic                     mst_b_ready_o
);

  import axi_proto_pkg::*;
  import dw_chan_pkg::*;

  typedef enum logic [1:0] {
    WIdle,
    WPass,
    WUpsize
  } w_state_e;

  w_state_e    state_d, state_q;
  aw_chan_t    aw_plan;
  logic        aw_upsize;
  aw_chan_t    aw_d, aw_q;
  logic        aw_valid_d, aw_valid_q;
  mst_w_chan_t w_d, w_q;
  logic        w_valid_d, w_valid_q;
  // Narrow address, length and size of the next narrow beat
  addr_t       addr_d, addr_q;
  len_t        len_d, len_q;
  size_t       size_d, size_q;

  upsize_burst_plan #(
    .ax_chan_t(aw_chan_t)
  ) i_aw_plan (
    .ax_i    (slv_aw_i),
    .ax_o    (aw_plan),
    .upsize_o(aw_upsize)
  );

  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = aw_valid_q;
  assign mst_w_o        = w_q;
  assign mst_w_valid_o  = w_valid_q;

  // B has no latency
  assign slv_b_o       = mst_b_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

  always_comb begin
    int mst_off;
    int lane_base;
    int lane_lo;
    int lane_hi;

    state_d        = state_q;
    aw_d           = aw_q;
    aw_valid_d     = aw_valid_q;
    w_d            = w_q;
    w_valid_d      = w_valid_q;
    addr_d         = addr_q;
    len_d          = len_q;
    size_d         = size_q;
    slv_aw_ready_o = 1'b0;
    slv_w_ready_o  = 1'b0;

    // Narrow lanes of this beat and where they land in the wide word
    mst_off   = int'(addr_q[MstSizeLog-1:0]);
    lane_lo   = mst_off % SlvStrbWidth;
    lane_base = mst_off - lane_lo;
    lane_hi   = ((lane_lo >> size_q) << size_q) + (1 << size_q);

    if (mst_aw_valid_o && mst_aw_ready_i) begin
      aw_valid_d = 1'b0;
    end

    // Wide beat drained
    if (mst_w_valid_o && mst_w_ready_i) begin
      w_valid_d  = 1'b0;
      w_d.data   = '0;
      w_d.strb   = '0;
      if (w_q.last) begin
        state_d = WIdle;
      end
    end

    case (state_q)
      WIdle: begin
        slv_aw_ready_o = 1'b1;
        if (slv_aw_valid_i) begin
          aw_d       = aw_plan;
          aw_valid_d = 1'b1;
          addr_d     = slv_aw_i.addr;
          len_d      = slv_aw_i.len;
          size_d     = slv_aw_i.size;
          w_d        = '0;
          state_d    = aw_upsize ? WUpsize : WPass;
        end
      end
      WPass, WUpsize: begin
        // Hold off once the last narrow beat sits in the wide register
        slv_w_ready_o = !aw_valid_q && !(w_valid_q && w_q.last) &&
                        (!w_valid_q || mst_w_ready_i);
        if (slv_w_valid_i && slv_w_ready_o) begin
          for (int n = 0; n < SlvStrbWidth; n++) begin
            if (n >= lane_lo && n < lane_hi) begin
              w_d.data[8*(lane_base+n) +: 8] = slv_w_i.data[8*n +: 8];
              w_d.strb[lane_base+n]          = slv_w_i.strb[n];
            end
          end
          len_d    = len_q - 1'b1;
          addr_d   = addr_t'(aligned_addr(largest_addr_t'(addr_q), size_q)) +
                     (addr_t'(1) << size_q);
          w_d.last = (len_q == '0);
          // Upsized words go out when full or at the end of the burst
          if (state_q == WPass || len_q == '0 ||
              addr_d[AddrWidth-1:MstSizeLog] != addr_q[AddrWidth-1:MstSizeLog]) begin
            w_valid_d = 1'b1;
          end
        end
      end
      default: state_d = WIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= WIdle;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      aw_valid_q <= aw_valid_d;
      w_valid_q  <= w_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    aw_q   <= aw_d;
    w_q    <= w_d;
    addr_q <= addr_d;
    len_q  <= len_d;
    size_q <= size_d;
  end

endmodule

`default_nettype wire

// ==== rtl/upsize_read_ctrl.sv ====
// Upsizer read path
`default_nettype none

module upsize_read_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dw_chan_pkg::ar_chan_t    slv_ar_i,
  input  logic                     slv_ar_valid_i,
  output logic                     slv_ar_ready_o,
  output dw_chan_pkg::slv_r_chan_t slv_r_o,
  output logic                     slv_r_valid_o,
  input  logic                     slv_r_ready_i,
  output dw_chan_pkg::ar_chan_t    mst_ar_o,
  output logic                     mst_ar_valid_o,
  input  logic                     mst_ar_ready_i,
  input  dw_chan_pkg::mst_r_chan_t mst_r_i,
  input  logic                     mst_r_valid_i,
  output logic                     mst_r_ready_o
);

  import axi_proto_pkg::*;
  import dw_chan_pkg::*;

  typedef enum logic [1:0] {
    RIdle,
    RPass,
    RUpsize
  } r_state_e;

  r_state_e state_d, state_q;
  ar_chan_t ar_plan;
  logic     ar_upsize;
  ar_chan_t ar_d, ar_q;
  logic     ar_valid_d, ar_valid_q;
  addr_t    addr_d, addr_q;
  // Narrow beats left after the current one
  len_t     len_d, len_q;
  size_t    size_d, size_q;

  upsize_burst_plan #(
    .ax_chan_t(ar_chan_t)
  ) i_ar_plan (
    .ax_i    (slv_ar_i),
    .ax_o    (ar_plan),
    .upsize_o(ar_upsize)
  );

  assign mst_ar_o       = ar_q;
  assign mst_ar_valid_o = ar_valid_q;
  assign slv_ar_ready_o = (state_q == RIdle);

  always_comb begin
    int mst_off;
    int lane_base;
    int lane_lo;
    int lane_hi;

    state_d       = state_q;
    ar_d          = ar_q;
    ar_valid_d    = ar_valid_q;
    addr_d        = addr_q;
    len_d         = len_q;
    size_d        = size_q;
    mst_r_ready_o = 1'b0;

    mst_off   = int'(addr_q[MstSizeLog-1:0]);
    lane_lo   = mst_off % SlvStrbWidth;
    lane_base = mst_off - lane_lo;
    lane_hi   = ((lane_lo >> size_q) << size_q) + (1 << size_q);

    // Narrow beat straight from the wide beat
    slv_r_o       = '0;
    slv_r_o.id    = mst_r_i.id;
    slv_r_o.resp  = mst_r_i.resp;
    slv_r_o.last  = mst_r_i.last && (len_q == '0);
    slv_r_valid_o = (state_q != RIdle) && !ar_valid_q && mst_r_valid_i;
    for (int n = 0; n < SlvStrbWidth; n++) begin
      if (n >= lane_lo && n < lane_hi) begin
        slv_r_o.data[8*n +: 8] = mst_r_i.data[8*(lane_base+n) +: 8];
      end
    end

    if (mst_ar_valid_o && mst_ar_ready_i) begin
      ar_valid_d = 1'b0;
    end

    case (state_q)
      RIdle: begin
        if (slv_ar_valid_i) begin
          ar_d       = ar_plan;
          ar_valid_d = 1'b1;
          addr_d     = slv_ar_i.addr;
          len_d      = slv_ar_i.len;
          size_d     = slv_ar_i.size;
          state_d    = ar_upsize ? RUpsize : RPass;
        end
      end
      RPass, RUpsize: begin
        if (slv_r_valid_o && slv_r_ready_i) begin
          len_d  = len_q - 1'b1;
          addr_d = addr_t'(aligned_addr(largest_addr_t'(addr_q), size_q)) +
                   (addr_t'(1) << size_q);
          // Keep the wide beat until its last narrow lane has gone out
          if (state_q == RPass || len_q == '0 ||
              addr_d[AddrWidth-1:MstSizeLog] != addr_q[AddrWidth-1:MstSizeLog]) begin
            mst_r_ready_o = 1'b1;
          end
          if (len_q == '0) begin
            state_d = RIdle;
          end
        end
      end
      default: state_d = RIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RIdle;
      ar_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      ar_valid_q <= ar_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ar_q   <= ar_d;
    addr_q <= addr_d;
    len_q  <= len_d;
    size_q <= size_d;
  end

endmodule

`default_nettype wire

// ==== rtl/axi_dw_upsizer.sv ====
// AXI 32 to 64 bit upsizer
`default_nettype none

module axi_dw_upsizer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Narrow slave port
  input  dw_chan_pkg::aw_chan_t    slv_aw_i,
  input  logic                     slv_aw_valid_i,
  output logic                     slv_aw_ready_o,
  input  dw_chan_pkg::slv_w_chan_t slv_w_i,
  input  logic                     slv_w_valid_i,
  output logic                     slv_w_ready_o,
  output dw_chan_pkg::b_chan_t     slv_b_o,
  output logic                     slv_b_valid_o,
  input  logic                     slv_b_ready_i,
  input  dw_chan_pkg::ar_chan_t    slv_ar_i,
  input  logic                     slv_ar_valid_i,
  output logic                     slv_ar_ready_o,
  output dw_chan_pkg::slv_r_chan_t slv_r_o,
  output logic                     slv_r_valid_o,
  input  logic                     slv_r_ready_i,
  // Wide master port
  output dw_chan_pkg::aw_chan_t    mst_aw_o,
  output logic                     mst_aw_valid_o,
  input  logic                     mst_aw_ready_i,
  output dw_chan_pkg::mst_w_chan_t mst_w_o,
  output logic                     mst_w_valid_o,
  input  logic                     mst_w_ready_i,
  input  dw_chan_pkg::b_chan_t     mst_b_i,
  input  logic                     mst_b_valid_i,
  output logic                     mst_b_ready_o,
  output dw_chan_pkg::ar_chan_t    mst_ar_o,
  output logic                     mst_ar_valid_o,
  input  logic                     mst_ar_ready_i,
  input  dw_chan_pkg::mst_r_chan_t mst_r_i,
  input  logic                     mst_r_valid_i,
  output logic                     mst_r_ready_o
);

  // AW, W and B
  upsize_write_ctrl i_write_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_aw_i      (slv_aw_i),
    .slv_aw_valid_i(slv_aw_valid_i),
    .slv_aw_ready_o(slv_aw_ready_o),
    .slv_w_i       (slv_w_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .slv_b_o       (slv_b_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i),
    .mst_aw_o      (mst_aw_o),
    .mst_aw_valid_o(mst_aw_valid_o),
    .mst_aw_ready_i(mst_aw_ready_i),
    .mst_w_o       (mst_w_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i),
    .mst_b_i       (mst_b_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o)
  );

  // AR and R with one read in flight
  upsize_read_ctrl i_read_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_ar_i      (slv_ar_i),
    .slv_ar_valid_i(slv_ar_valid_i),
    .slv_ar_ready_o(slv_ar_ready_o),
    .slv_r_o       (slv_r_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i),
    .mst_ar_o      (mst_ar_o),
    .mst_ar_valid_o(mst_ar_valid_o),
    .mst_ar_ready_i(mst_ar_ready_i),
    .mst_r_i       (mst_r_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o)
  );

endmodule

`default_nettype wire

// ==== verif/upsizer_assert.sv ====
// Wide side handshake checks
`default_nettype none

module upsizer_assert (
  input logic                     clk_i,
  input logic                     rst_ni,
  input dw_chan_pkg::aw_chan_t    mst_aw_o,
  input logic                     mst_aw_valid_o,
  input logic                     mst_aw_ready_i,
  input dw_chan_pkg::mst_w_chan_t mst_w_o,
  input logic                     mst_w_valid_o,
  input logic                     mst_w_ready_i
);

  logic [7:0] w_len_q;
  logic [7:0] w_cnt_q;

  // Wide beats seen since the last wide AW
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_len_q <= '0;
      w_cnt_q <= '0;
    end else if (mst_aw_valid_o && mst_aw_ready_i) begin
      w_len_q <= mst_aw_o.len;
      w_cnt_q <= '0;
    end else if (mst_w_valid_o && mst_w_ready_i) begin
      w_cnt_q <= w_cnt_q + 8'd1;
    end
  end

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o))
    else $error("wide AW dropped or changed before ready");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o && $stable(mst_w_o))
    else $error("wide W dropped or changed before ready");

  w_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_o |-> (mst_w_o.last == (w_cnt_q == w_len_q)))
    else $error("wide W last on the wrong beat");

endmodule

`default_nettype wire

// ==== verif/tb_axi_dw_upsizer.sv ====
// Upsizer testbench
`default_nettype none

module tb_axi_dw_upsizer;

  import axi_proto_pkg::*;
  import dw_chan_pkg::*;

  typedef struct packed {
    logic   wr;
    addr_t  addr;
    len_t   len;
    size_t  size;
    cache_t cache;
    burst_t burst;
  } row_t;

  localparam int NumRows = 10;

  logic clk_i;
  logic rst_ni;
  aw_chan_t    slv_aw_i, mst_aw_o;
  ar_chan_t    slv_ar_i, mst_ar_o;
  slv_w_chan_t slv_w_i;
  mst_w_chan_t mst_w_o;
  b_chan_t     slv_b_o, mst_b_i;
  slv_r_chan_t slv_r_o;
  mst_r_chan_t mst_r_i;
  logic slv_aw_valid_i, slv_aw_ready_o, slv_w_valid_i, slv_w_ready_o;
  logic slv_b_valid_o, slv_b_ready_i, slv_ar_valid_i, slv_ar_ready_o;
  logic slv_r_valid_o, slv_r_ready_i, mst_aw_valid_o, mst_aw_ready_i;
  logic mst_w_valid_o, mst_w_ready_i, mst_b_valid_i, mst_b_ready_o;
  logic mst_ar_valid_o, mst_ar_ready_i, mst_r_valid_i, mst_r_ready_o;

  row_t       rows [NumRows];
  logic [7:0] mem [256];
  logic [7:0] ref_mem [256];
  logic [7:0] exp_strb_q [$];
  logic [31:0] lfsr_q = 32'h976b_1ae6;
  // Expected wide request of the current row
  len_t   exp_len;
  size_t  exp_size;
  addr_t  exp_addr;
  id_t    exp_id;
  burst_t exp_burst;
  cache_t exp_cache;
  logic   exp_pass;
  int aw_cnt, w_beats, ar_cnt, r_beats;

  axi_dw_upsizer i_axi_dw_upsizer (.*);

  bind axi_dw_upsizer upsizer_assert i_upsizer_assert (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rand_bit()};
    end
    return r;
  endfunction

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("Errors found");
      $fatal(1, "check failed");
    end
  endtask

  // Address of beat n of an INCR burst
  function automatic addr_t beat_addr(addr_t a, size_t s, int n);
    if (n == 0) begin
      return a;
    end
    return (a & ~((addr_t'(1) << s) - addr_t'(1))) + (addr_t'(n) << s);
  endfunction

  // Active byte lanes of a narrow beat
  function automatic logic [3:0] narrow_mask(addr_t a, size_t s);
    addr_t al;
    int lo;
    int hi;
    logic [3:0] m;
    al = a & ~((addr_t'(1) << s) - addr_t'(1));
    lo = int'(a[1:0]);
    hi = int'(al[1:0]) + (1 << s);
    m  = '0;
    for (int k = 0; k < 4; k++) begin
      m[k] = (k >= lo) && (k < hi);
    end
    return m;
  endfunction

  // Wide length after the burst reshaping rule
  function automatic len_t expected_len(row_t r);
    addr_t first;
    addr_t last_beat;
    if (!(r.cache[1] && r.burst == BurstIncr)) begin
      return r.len;
    end
    first     = r.addr & ~((addr_t'(1) << r.size) - addr_t'(1));
    last_beat = first + (addr_t'(r.len) << r.size);
    return len_t'((last_beat >> 3) - (r.addr >> 3));
  endfunction

  // Wide memory model
  always begin : wide_memory
    addr_t a;
    logic b_done;
    logic r_done;
    logic b_pend;
    id_t b_id;
    addr_t w_addr, r_addr;
    size_t w_size, r_size;
    len_t r_len;
    id_t r_id;
    logic r_active;
    int w_n, r_n;

    @(negedge clk_i);
    b_done = 1'b0;
    r_done = 1'b0;
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      check_val("mst_aw_o.len", 64'(mst_aw_o.len), 64'(exp_len));
      check_val("mst_aw_o.size", 64'(mst_aw_o.size), 64'(exp_size));
      check_val("mst_aw_o.addr", 64'(mst_aw_o.addr), 64'(exp_addr));
      check_val("mst_aw_o.id", 64'(mst_aw_o.id), 64'(exp_id));
      check_val("mst_aw_o.burst", 64'(mst_aw_o.burst), 64'(exp_burst));
      check_val("mst_aw_o.cache", 64'(mst_aw_o.cache), 64'(exp_cache));
      w_addr = mst_aw_o.addr;
      w_size = mst_aw_o.size;
      b_id   = mst_aw_o.id;
      w_n    = 0;
      aw_cnt++;
    end
    if (mst_w_valid_o && mst_w_ready_i) begin
      a = beat_addr(w_addr, w_size, w_n);
      for (int k = 0; k < 8; k++) begin
        if (mst_w_o.strb[k]) begin
          mem[{a[7:3], 3'b000} + 8'(k)] = mst_w_o.data[8*k +: 8];
        end
      end
      check_val("mst_w_o.last", 64'(mst_w_o.last), 64'(w_n == int'(exp_len)));
      if (exp_pass) begin
        check_val("mst_w_o.strb", 64'(mst_w_o.strb), 64'(exp_strb_q.pop_front()));
      end
      if (mst_w_o.last) begin
        b_pend = 1'b1;
      end
      w_n++;
      w_beats++;
    end
    if (mst_b_valid_i && mst_b_ready_o) begin
      b_done = 1'b1;
      b_pend = 1'b0;
    end
    if (mst_ar_valid_o && mst_ar_ready_i) begin
      check_val("mst_ar_o.len", 64'(mst_ar_o.len), 64'(exp_len));
      check_val("mst_ar_o.size", 64'(mst_ar_o.size), 64'(exp_size));
      check_val("mst_ar_o.addr", 64'(mst_ar_o.addr), 64'(exp_addr));
      check_val("mst_ar_o.id", 64'(mst_ar_o.id), 64'(exp_id));
      check_val("mst_ar_o.burst", 64'(mst_ar_o.burst), 64'(exp_burst));
      check_val("mst_ar_o.cache", 64'(mst_ar_o.cache), 64'(exp_cache));
      r_addr   = mst_ar_o.addr;
      r_size   = mst_ar_o.size;
      r_len    = mst_ar_o.len;
      r_id     = mst_ar_o.id;
      r_n      = 0;
      r_active = 1'b1;
      ar_cnt++;
    end
    if (mst_r_valid_i && mst_r_ready_o) begin
      r_done = 1'b1;
      r_n++;
      r_beats++;
      r_active = (r_n <= int'(r_len));
    end

    @(posedge clk_i);
    #1;
    mst_aw_ready_i = rand_bit();
    mst_w_ready_i  = rand_bit();
    mst_ar_ready_i = rand_bit();
    if (b_done) begin
      mst_b_valid_i = 1'b0;
    end else if (b_pend === 1'b1 && !mst_b_valid_i && rand_bit()) begin
      mst_b_valid_i = 1'b1;
      mst_b_i.id    = b_id;
      mst_b_i.resp  = RespOkay;
    end
    if (r_done) begin
      mst_r_valid_i = 1'b0;
    end
    if (r_active === 1'b1 && !mst_r_valid_i && rand_bit()) begin
      a = beat_addr(r_addr, r_size, r_n);
      for (int k = 0; k < 8; k++) begin
        mst_r_i.data[8*k +: 8] = mem[{a[7:3], 3'b000} + 8'(k)];
      end
      mst_r_i.id    = r_id;
      mst_r_i.resp  = RespOkay;
      mst_r_i.last  = (r_n == int'(r_len));
      mst_r_valid_i = 1'b1;
    end
  end

  // Sets up the expected wide request for one row
  task automatic plan_row(row_t r, int idx);
    exp_len   = expected_len(r);
    exp_pass  = !(r.cache[1] && r.burst == BurstIncr);
    exp_size  = exp_pass ? r.size : size_t'(MstSizeLog);
    exp_addr  = r.addr;
    exp_id    = id_t'(idx);
    exp_burst = r.burst;
    exp_cache = r.cache;
    aw_cnt    = 0;
    w_beats   = 0;
    ar_cnt    = 0;
    r_beats   = 0;
    exp_strb_q.delete();
  endtask

  task automatic run_write(row_t r, int idx);
    addr_t a;
    logic [3:0] m;
    logic [31:0] d;
    logic got;

    plan_row(r, idx);
    slv_aw_i       = '{exp_id, r.addr, r.len, r.size, r.burst, r.cache};
    slv_aw_valid_i = 1'b1;
    @(negedge clk_i);
    while (!slv_aw_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    slv_aw_valid_i = 1'b0;
    for (int n = 0; n <= int'(r.len); n++) begin
      a = beat_addr(r.addr, r.size, n);
      m = narrow_mask(a, r.size);
      d = rand_bits(32);
      for (int k = 0; k < 4; k++) begin
        if (m[k]) begin
          ref_mem[{a[7:2], 2'b00} + 8'(k)] = d[8*k +: 8];
        end
      end
      exp_strb_q.push_back(a[2] ? {m, 4'b0000} : {4'b0000, m});
      // Random gaps between narrow beats
      while (rand_bit()) begin
        @(posedge clk_i);
        #1;
      end
      slv_w_i       = '{d, m, n == int'(r.len)};
      slv_w_valid_i = 1'b1;
      @(negedge clk_i);
      while (!slv_w_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1;
      slv_w_valid_i = 1'b0;
    end
    got = 1'b0;
    while (!got) begin
      @(posedge clk_i);
      #1;
      slv_b_ready_i = rand_bit();
      @(negedge clk_i);
      got = slv_b_valid_o && slv_b_ready_i;
    end
    check_val("slv_b_o.id", 64'(slv_b_o.id), 64'(exp_id));
    check_val("slv_b_o.resp", 64'(slv_b_o.resp), 64'(RespOkay));
    @(posedge clk_i);
    #1;
    slv_b_ready_i = 1'b0;
    check_val("aw_count", 64'(aw_cnt), 64'd1);
    check_val("wide_w_beats", 64'(w_beats), 64'(exp_len) + 64'd1);
    for (int i = 0; i < 256; i++) begin
      check_val($sformatf("mem[%0h]", i), 64'(mem[i]), 64'(ref_mem[i]));
    end
  endtask

  task automatic run_read(row_t r, int idx);
    addr_t a;
    logic [3:0] m;
    logic [31:0] exp_d;
    logic [31:0] lane_mask;
    logic got;

    plan_row(r, idx);
    slv_ar_i       = '{exp_id, r.addr, r.len, r.size, r.burst, r.cache};
    slv_ar_valid_i = 1'b1;
    @(negedge clk_i);
    while (!slv_ar_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    slv_ar_valid_i = 1'b0;
    for (int n = 0; n <= int'(r.len); n++) begin
      a = beat_addr(r.addr, r.size, n);
      m = narrow_mask(a, r.size);
      exp_d     = '0;
      lane_mask = '0;
      for (int k = 0; k < 4; k++) begin
        if (m[k]) begin
          exp_d[8*k +: 8]     = ref_mem[{a[7:2], 2'b00} + 8'(k)];
          lane_mask[8*k +: 8] = 8'hff;
        end
      end
      got = 1'b0;
      while (!got) begin
        slv_r_ready_i = rand_bit();
        @(negedge clk_i);
        got = slv_r_valid_o && slv_r_ready_i;
        // Narrow beat sampled in its handshake cycle
        if (got) begin
          check_val("slv_r_o.data", 64'(slv_r_o.data & lane_mask), 64'(exp_d));
          check_val("slv_r_o.last", 64'(slv_r_o.last), 64'(n == int'(r.len)));
          check_val("slv_r_o.id", 64'(slv_r_o.id), 64'(exp_id));
          check_val("slv_r_o.resp", 64'(slv_r_o.resp), 64'(RespOkay));
        end
        @(posedge clk_i);
        #1;
      end
      slv_r_ready_i = 1'b0;
    end
    check_val("ar_count", 64'(ar_cnt), 64'd1);
    check_val("wide_r_beats", 64'(r_beats), 64'(exp_len) + 64'd1);
  endtask

  initial begin : watchdog
    repeat (NumRows * 200) @(posedge clk_i);
    $display("Timeout: the tests did not finish in the allowed cycles");
    $display("Errors found");
    $fatal(1, "timeout");
  end

  initial begin : main
    // wr, addr, len, size, cache, burst
    rows[0] = '{1'b1, 32'h10, 8'd3, 3'd2, 4'h0, BurstIncr};
    rows[1] = '{1'b1, 32'h24, 8'd4, 3'd2, 4'h2, BurstIncr};
    rows[2] = '{1'b1, 32'h41, 8'd5, 3'd1, 4'h2, BurstIncr};
    rows[3] = '{1'b1, 32'h60, 8'd7, 3'd0, 4'h2, BurstIncr};
    rows[4] = '{1'b0, 32'h10, 8'd3, 3'd2, 4'h0, BurstIncr};
    rows[5] = '{1'b0, 32'h24, 8'd4, 3'd2, 4'h2, BurstIncr};
    rows[6] = '{1'b0, 32'h40, 8'd5, 3'd1, 4'h2, BurstIncr};
    rows[7] = '{1'b0, 32'h60, 8'd7, 3'd0, 4'h0, BurstIncr};
    rows[8] = '{1'b1, 32'h84, 8'd2, 3'd2, 4'h3, BurstIncr};
    rows[9] = '{1'b0, 32'h80, 8'd3, 3'd2, 4'h2, BurstIncr};
    for (int i = 0; i < 256; i++) begin
      mem[i]     = 8'(i) ^ 8'ha5;
      ref_mem[i] = 8'(i) ^ 8'ha5;
    end
    rst_ni         = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_i        = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_i        = '0;
    mst_b_valid_i  = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_i        = '0;
    mst_r_valid_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      if (rows[i].wr) begin
        run_write(rows[i], i);
      end else begin
        run_read(rows[i], i);
      end
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/axi_proto_pkg.sv
rtl/dw_chan_pkg.sv
rtl/upsize_burst_plan.sv
rtl/upsize_write_ctrl.sv
rtl/upsize_read_ctrl.sv
rtl/axi_dw_upsizer.sv
verif/upsizer_assert.sv
verif/tb_axi_dw_upsizer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the upsizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f compile.f \
  --top-module tb_axi_dw_upsizer -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/Vtb_axi_dw_upsizer > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
if grep -q "^No errors$" sim.log; then
  exit 0
fi
exit 1
